//--- build.f
aes_bram_pkg.sv
aes_lane_pkg.sv
aes_job_regs.sv
aes_word_gather.sv
aes_word_scatter.sv
aes_chunk_seq.sv
aes_chunk_top.sv
tb_clock_gen.sv
tb_aes_chunk.sv

//--- Bender.yml
package:
  name: aes_chunk_engine

sources:
  - aes_bram_pkg.sv
  - aes_lane_pkg.sv
  - aes_job_regs.sv
  - aes_word_gather.sv
  - aes_word_scatter.sv
  - aes_chunk_seq.sv
  - aes_chunk_top.sv
  - target: simulation
    files:
      - tb_clock_gen.sv
      - tb_aes_chunk.sv

//--- tb_aes_chunk.sv
`timescale 1ns/1ps

module tb_aes_chunk;

    localparam int N_JOBS = 5;

    logic aes_clk, aes_rst_n, axi_start_aes, bram_complete, aes_start_read, aes_start_write;
    logic core_init, aes_complete;
    logic [3:0] core_ready, core_next;
    aes_bram_pkg::count_t aes_num_chunks, read_cycles, key_wait_cycles, cipher_cycles;
    aes_bram_pkg::count_t write_cycles;
    aes_bram_pkg::addr_t aes_bram_addr_start, aes_bram_write_addr_start, aes_bram_addr;
    aes_bram_pkg::addr_t aes_bram_write_addr;
    aes_bram_pkg::word_t aes_bram_read_data, aes_bram_write_data;
    aes_lane_pkg::key_t aes_key_input, core_key;
    aes_lane_pkg::block_t [3:0] core_result, core_block;

    int seed, core_seed, n_reads, n_writes, n_inits, exp_words, core_busy[4];
    logic start_pending, prev_rd, prev_wr, prev_bram_cpl, prev_next, prev_init, prev_done;
    aes_bram_pkg::count_t prev_cnt[4];
    aes_bram_pkg::addr_t job_rbase, job_wbase;
    aes_lane_pkg::key_t job_key, last_key, keys[2], core_key_q;
    aes_lane_pkg::block_t core_blk_q[4];
    aes_bram_pkg::word_t bram_mem[aes_bram_pkg::addr_t];
    aes_bram_pkg::word_t read_words[$];

    int job_chunks[N_JOBS] = '{1, 3, 0, 1, 2};
    int job_key_sel[N_JOBS] = '{0, 0, 1, 1, 0};

    tb_clock_gen #(.PERIOD_NS(10), .RESET_CYCLES(4)) clock_gen_inst (
        .aes_clk(aes_clk), .aes_rst_n(aes_rst_n)
    );

    aes_chunk_top #(.N_LANES(4)) aes_chunk_top_inst (.*);

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else
            stop_on_error($sformatf("ERR %0t %s expected %h actual %h", $time, name, exp, act));
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond === 1'b1) else stop_on_error($sformatf("At %0t: %s", $time, what));
    endtask

    // Unwritten locations return a pattern of the whole address
    function automatic aes_bram_pkg::word_t read_word(input aes_bram_pkg::addr_t a);
        if (bram_mem.exists(a)) return bram_mem[a];
        return {a[15:0], ~a[31:16]} ^ 32'h3c5a_96e1;
    endfunction

    // Each result word is its read word XOR the matching slice of the low key half
    function automatic aes_bram_pkg::word_t expected_result(input int k);
        return read_words[k] ^ job_key[(3 - (k % 4)) * 32 +: 32];
    endfunction

    task automatic check_reset_outputs();
        check_value("aes_start_read", 0, aes_start_read);
        check_value("aes_start_write", 0, aes_start_write);
        check_value("core_init", 0, core_init);
        check_value("core_next", 0, core_next);
        check_value("aes_complete", 0, aes_complete);
        check_value("read_cycles", 0, read_cycles);
        check_value("key_wait_cycles", 0, key_wait_cycles);
        check_value("cipher_cycles", 0, cipher_cycles);
        check_value("write_cycles", 0, write_cycles);
    endtask

    //////////////////////////////////////////////////////////////////////
    // BRAM and core models
    //////////////////////////////////////////////////////////////////////

    initial begin : bram_model
        int delay;
        forever begin
            @(posedge aes_clk);
            #1;
            if (!aes_rst_n && (aes_start_read || aes_start_write)) begin
                delay = 1 + ($unsigned($random(seed)) % 4);
                repeat (delay) @(posedge aes_clk);
                #1;
                if (aes_start_write) bram_mem[aes_bram_write_addr] = aes_bram_write_data;
                else aes_bram_read_data = read_word(aes_bram_addr);
                bram_complete = 1'b1;
                @(posedge aes_clk);
                #1 bram_complete = 1'b0;
            end
        end
    end

    initial begin : core_model
        logic       init_s;
        logic [3:0] next_s;
        forever begin
            @(negedge aes_clk);
            init_s = core_init;
            next_s = core_next;
            @(posedge aes_clk);
            #1;
            if (init_s === 1'b1) core_key_q = core_key;
            for (int l = 0; l < 4; l++) begin
                if (init_s === 1'b1 || next_s[l] === 1'b1) begin
                    core_ready[l] = 1'b0;
                    core_busy[l]  = 1 + ($unsigned($random(core_seed)) % 6);
                    if (next_s[l] === 1'b1) core_blk_q[l] = core_block[l];
                end else if (core_busy[l] > 0) begin
                    core_busy[l]--;
                    if (core_busy[l] == 0) begin
                        core_ready[l]  = 1'b1;
                        core_result[l] = core_blk_q[l] ^ core_key_q[127:0];
                    end
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Protocol monitor, sampled mid-cycle
    //////////////////////////////////////////////////////////////////////

    always @(negedge aes_clk) begin
        if (!aes_rst_n) begin
            check_true(!(aes_start_read && aes_start_write), "read and write requests overlap");
            if (prev_rd && !prev_bram_cpl) check_true(aes_start_read, "read dropped early");
            if (prev_wr && !prev_bram_cpl) check_true(aes_start_write, "write dropped early");
            check_true(core_next == '0 || (core_next == '1 && core_ready == '1),
                       "core_next not on all lanes together with all cores ready");
            check_true(!(prev_next && |core_next), "core_next held longer than one cycle");
            check_true(!(prev_init && core_init), "core_init held longer than one cycle");
            if (core_init) n_inits++;
            if (aes_start_read && bram_complete) begin
                check_value("aes_bram_addr", job_rbase + 4 * n_reads, aes_bram_addr);
                read_words.push_back(aes_bram_read_data);
                n_reads++;
            end
            if (aes_start_write && bram_complete) begin
                check_true(n_writes < n_reads, "write issued before its word was read");
                check_value("aes_bram_write_addr", job_wbase + 4 * n_writes, aes_bram_write_addr);
                check_value("aes_bram_write_data", expected_result(n_writes), aes_bram_write_data);
                check_value("aes_complete", 0, aes_complete);
                n_writes++;
            end
            if (aes_complete && !prev_done) begin
                check_value("writes at aes_complete", exp_words, n_writes);
            end
            if (prev_done && !aes_complete) begin
                check_true(start_pending, "aes_complete fell without a start");
            end
            check_true(read_cycles >= prev_cnt[0] && key_wait_cycles >= prev_cnt[1] &&
                       cipher_cycles >= prev_cnt[2] && write_cycles >= prev_cnt[3],
                       "a phase cycle counter decreased");
        end
        prev_rd       = aes_start_read;
        prev_wr       = aes_start_write;
        prev_bram_cpl = bram_complete;
        prev_next     = |core_next;
        prev_init     = core_init;
        prev_done     = aes_complete;
        prev_cnt      = '{read_cycles, key_wait_cycles, cipher_cycles, write_cycles};
    end

    //////////////////////////////////////////////////////////////////////
    // Jobs and watchdog
    //////////////////////////////////////////////////////////////////////

    task automatic run_job(input int j);
        int eff;
        aes_bram_pkg::count_t rc0, kc0, cc0, wc0;
        eff       = (job_chunks[j] == 0) ? 1 : job_chunks[j];
        job_rbase = 32'h1000 * (j + 1);
        job_wbase = 32'h8000 + 32'h1000 * j;
        job_key   = keys[job_key_sel[j]];
        exp_words = eff * 16;
        n_reads   = 0;
        n_writes  = 0;
        n_inits   = 0;
        read_words.delete();
        @(posedge aes_clk);
        #1;
        rc0 = read_cycles;
        kc0 = key_wait_cycles;
        cc0 = cipher_cycles;
        wc0 = write_cycles;
        aes_num_chunks            = job_chunks[j];
        aes_bram_addr_start       = job_rbase;
        aes_bram_write_addr_start = job_wbase;
        aes_key_input             = job_key;
        axi_start_aes             = 1'b1;
        start_pending             = 1'b1;
        @(posedge aes_clk);
        #1 axi_start_aes = 1'b0;
        @(posedge aes_clk);
        while (aes_complete !== 1'b1) @(posedge aes_clk);
        #1;
        check_value("read count", exp_words, n_reads);
        check_value("write count", exp_words, n_writes);
        // Reload due for a new key or when nothing was loaded since reset
        check_value("core_init pulses", (job_key != last_key || last_key == '0), n_inits);
        check_true(read_cycles - rc0 >= 48 * eff, "read_cycles grew too little");
        check_true(write_cycles - wc0 >= 64 * eff, "write_cycles grew too little");
        check_true(key_wait_cycles - kc0 >= eff, "key_wait_cycles did not grow in every chunk");
        check_true(cipher_cycles - cc0 >= eff, "cipher_cycles did not grow in every chunk");
        last_key      = job_key;
        start_pending = 1'b0;
        repeat (5) @(posedge aes_clk);
    endtask

    initial begin : watchdog
        int limit;
        limit = 100;
        for (int j = 0; j < N_JOBS; j++)
            limit += ((job_chunks[j] == 0) ? 1 : job_chunks[j]) * (16 * 2 * 8 + 2 * 200) + 20;
        #(limit * 10);
        stop_on_error($sformatf("Watchdog expired after %0d cycles without finishing", limit));
    end

    initial begin
        seed                      = 20;
        core_seed                 = 20;
        axi_start_aes             = 1'b0;
        bram_complete             = 1'b0;
        start_pending             = 1'b0;
        aes_num_chunks            = '0;
        aes_bram_addr_start       = '0;
        aes_bram_write_addr_start = '0;
        aes_key_input             = '0;
        last_key                  = '0;
        aes_bram_read_data        = '0;
        core_result               = '0;
        core_ready                = 4'hf;
        for (int l = 0; l < 4; l++) begin
            core_busy[l] = 0;
        end
        for (int k = 0; k < 2; k++)
            for (int i = 0; i < 8; i++) keys[k][i * 32 +: 32] = $random(seed);
        repeat (2) @(posedge aes_clk);
        @(negedge aes_clk) check_reset_outputs();
        while (aes_rst_n) @(negedge aes_clk);
        check_reset_outputs();
        for (int j = 0; j < N_JOBS; j++) run_job(j);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 4
) (
    output logic aes_clk,
    output logic aes_rst_n
);

    initial begin
        aes_clk = 1'b0;
        forever #(PERIOD_NS / 2) aes_clk = ~aes_clk;
    end

    // Reset is active high
    initial begin
        aes_rst_n = 1'b1;
        repeat (RESET_CYCLES) @(posedge aes_clk);
        #1 aes_rst_n = 1'b0;
    end

endmodule

//--- aes_chunk_top.sv
`timescale 1ns/1ps

module aes_chunk_top #(
    parameter int N_LANES = 4
) (
    input  logic                                aes_clk,
    input  logic                                aes_rst_n,
    input  logic                                axi_start_aes,
    input  aes_bram_pkg::count_t                aes_num_chunks,
    input  aes_bram_pkg::addr_t                 aes_bram_addr_start,
    input  aes_bram_pkg::addr_t                 aes_bram_write_addr_start,
    input  aes_lane_pkg::key_t                  aes_key_input,
    input  logic                                bram_complete,
    input  aes_bram_pkg::word_t                 aes_bram_read_data,
    input  logic [N_LANES-1:0]                  core_ready,
    input  aes_lane_pkg::block_t [N_LANES-1:0]  core_result,
    output logic                                aes_start_read,
    output aes_bram_pkg::addr_t                 aes_bram_addr,
    output logic                                aes_start_write,
    output aes_bram_pkg::addr_t                 aes_bram_write_addr,
    output aes_bram_pkg::word_t                 aes_bram_write_data,
    output aes_lane_pkg::key_t                  core_key,
    output logic                                core_init,
    output logic [N_LANES-1:0]                  core_next,
    output aes_lane_pkg::block_t [N_LANES-1:0]  core_block,
    output logic                                aes_complete,
    output aes_bram_pkg::count_t                read_cycles,
    output aes_bram_pkg::count_t                key_wait_cycles,
    output aes_bram_pkg::count_t                cipher_cycles,
    output aes_bram_pkg::count_t                write_cycles
);

    logic                    capture_cfg;
    logic                    store_word;
    logic                    capture_results;
    logic                    reload_key;
    aes_bram_pkg::word_idx_t word_idx;
    aes_bram_pkg::count_t    chunk_total;
    aes_bram_pkg::addr_t     read_base_q;
    aes_bram_pkg::addr_t     write_base_q;

    // Cores see the live key, loaded only on core_init
    assign core_key = aes_key_input;

    aes_job_regs job_regs_inst (
        .aes_clk      (aes_clk),
        .aes_rst_n    (aes_rst_n),
        .capture      (capture_cfg),
        .num_chunks   (aes_num_chunks),
        .read_base    (aes_bram_addr_start),
        .write_base   (aes_bram_write_addr_start),
        .key          (aes_key_input),
        .chunk_total  (chunk_total),
        .read_base_q  (read_base_q),
        .write_base_q (write_base_q),
        .reload_key   (reload_key)
    );

    aes_chunk_seq #(.N_LANES(N_LANES)) chunk_seq_inst (
        .aes_clk          (aes_clk),
        .aes_rst_n        (aes_rst_n),
        .start            (axi_start_aes),
        .chunk_total      (chunk_total),
        .read_base        (read_base_q),
        .write_base       (write_base_q),
        .reload_key       (reload_key),
        .bram_complete    (bram_complete),
        .core_ready       (core_ready),
        .capture_cfg      (capture_cfg),
        .store_word       (store_word),
        .capture_results  (capture_results),
        .word_idx         (word_idx),
        .bram_start_read  (aes_start_read),
        .bram_start_write (aes_start_write),
        .bram_addr        (aes_bram_addr),
        .bram_write_addr  (aes_bram_write_addr),
        .core_init        (core_init),
        .core_next        (core_next),
        .aes_complete     (aes_complete),
        .read_cycles      (read_cycles),
        .key_wait_cycles  (key_wait_cycles),
        .cipher_cycles    (cipher_cycles),
        .write_cycles     (write_cycles)
    );

    aes_word_gather #(.N_LANES(N_LANES)) word_gather_inst (
        .aes_clk   (aes_clk),
        .aes_rst_n (aes_rst_n),
        .store     (store_word),
        .word_idx  (word_idx),
        .word      (aes_bram_read_data),
        .blocks    (core_block)
    );

    aes_word_scatter #(.N_LANES(N_LANES)) word_scatter_inst (
        .aes_clk   (aes_clk),
        .aes_rst_n (aes_rst_n),
        .capture   (capture_results),
        .results   (core_result),
        .word_idx  (word_idx),
        .word      (aes_bram_write_data)
    );

endmodule

//--- aes_chunk_seq.sv
`timescale 1ns/1ps

module aes_chunk_seq #(
    parameter int N_LANES = 4
) (
    input  logic                    aes_clk,
    input  logic                    aes_rst_n,
    input  logic                    start,
    input  aes_bram_pkg::count_t    chunk_total,
    input  aes_bram_pkg::addr_t     read_base,
    input  aes_bram_pkg::addr_t     write_base,
    input  logic                    reload_key,
    input  logic                    bram_complete,
    input  logic [N_LANES-1:0]      core_ready,
    output logic                    capture_cfg,
    output logic                    store_word,
    output logic                    capture_results,
    output aes_bram_pkg::word_idx_t word_idx,
    output logic                    bram_start_read,
    output logic                    bram_start_write,
    output aes_bram_pkg::addr_t     bram_addr,
    output aes_bram_pkg::addr_t     bram_write_addr,
    output logic                    core_init,
    output logic [N_LANES-1:0]      core_next,
    output logic                    aes_complete,
    output aes_bram_pkg::count_t    read_cycles,
    output aes_bram_pkg::count_t    key_wait_cycles,
    output aes_bram_pkg::count_t    cipher_cycles,
    output aes_bram_pkg::count_t    write_cycles
);

    localparam int CHUNK_WORDS = N_LANES * aes_lane_pkg::WORDS_PER_BLOCK;
    localparam aes_bram_pkg::word_idx_t LAST_WORD = aes_bram_pkg::word_idx_t'(CHUNK_WORDS - 1);
    // Scaled down from the full 16-word chunk when fewer cores are used
    localparam aes_bram_pkg::addr_t CHUNK_STEP = aes_bram_pkg::addr_t'(
        aes_bram_pkg::CHUNK_BYTES / aes_bram_pkg::WORDS_PER_CHUNK * CHUNK_WORDS);

    typedef enum logic [3:0] {
        S_IDLE,
        S_RD_REQ,
        S_RD_WAIT,
        S_RD_ADV,
        S_KEY,
        S_LAUNCH,
        S_CIPHER,
        S_WR_SEL,
        S_WR_REQ,
        S_WR_WAIT,
        S_WR_ADV
    } state_t;

    state_t               state;
    aes_bram_pkg::count_t chunk_no;
    aes_bram_pkg::addr_t  chunk_off;
    aes_bram_pkg::addr_t  word_off;
    logic                 key_due;
    logic                 all_ready;
    logic                 last_word;
    logic                 last_chunk;

    assign all_ready  = &core_ready;
    assign last_word  = (word_idx == LAST_WORD);
    assign last_chunk = ((chunk_no + 1'b1) == chunk_total);
    assign word_off   = aes_bram_pkg::addr_t'(word_idx) * aes_bram_pkg::WORD_BYTES;

    //////////////////////////////////////////////////////////////////////
    // Strobes decoded from the phase
    //////////////////////////////////////////////////////////////////////

    assign capture_cfg      = (state == S_IDLE) && start;
    assign store_word       = (state == S_RD_WAIT) && bram_complete;
    assign capture_results  = (state == S_CIPHER) && all_ready;
    assign bram_start_read  = (state == S_RD_REQ) || (state == S_RD_WAIT);
    assign bram_start_write = (state == S_WR_REQ) || (state == S_WR_WAIT);
    assign bram_addr        = read_base + chunk_off + word_off;
    assign bram_write_addr  = write_base + chunk_off + word_off;

    // Key schedule only once per job and only for a new key
    assign core_init = (state == S_KEY) && key_due && reload_key;
    assign core_next = {N_LANES{(state == S_LAUNCH) && all_ready}};

    //////////////////////////////////////////////////////////////////////
    // Phase machine and chunk loop
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge aes_clk) begin
        if (aes_rst_n) begin
            state        <= S_IDLE;
            word_idx     <= '0;
            chunk_no     <= '0;
            chunk_off    <= '0;
            key_due      <= 1'b0;
            aes_complete <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state        <= S_RD_REQ;
                        word_idx     <= '0;
                        chunk_no     <= '0;
                        chunk_off    <= '0;
                        key_due      <= 1'b1;
                        aes_complete <= 1'b0;
                    end
                end
                S_RD_REQ: begin
                    state <= S_RD_WAIT;
                end
                S_RD_WAIT: begin
                    if (bram_complete) begin
                        state <= S_RD_ADV;
                    end
                end
                S_RD_ADV: begin
                    if (last_word) begin
                        word_idx <= '0;
                        state    <= S_KEY;
                    end else begin
                        word_idx <= word_idx + 1'b1;
                        state    <= S_RD_REQ;
                    end
                end
                S_KEY: begin
                    key_due <= 1'b0;
                    state   <= S_LAUNCH;
                end
                S_LAUNCH: begin
                    if (all_ready) begin
                        state <= S_CIPHER;
                    end
                end
                S_CIPHER: begin
                    if (all_ready) begin
                        state <= S_WR_SEL;
                    end
                end
                S_WR_SEL: begin
                    state <= S_WR_REQ;
                end
                S_WR_REQ: begin
                    state <= S_WR_WAIT;
                end
                S_WR_WAIT: begin
                    if (bram_complete) begin
                        state <= S_WR_ADV;
                    end
                end
                S_WR_ADV: begin
                    if (!last_word) begin
                        word_idx <= word_idx + 1'b1;
                        state    <= S_WR_SEL;
                    end else if (last_chunk) begin
                        word_idx     <= '0;
                        aes_complete <= 1'b1;
                        state        <= S_IDLE;
                    end else begin
                        word_idx  <= '0;
                        chunk_no  <= chunk_no + 1'b1;
                        chunk_off <= chunk_off + CHUNK_STEP;
                        state     <= S_RD_REQ;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // Cumulative phase time since reset
    always_ff @(posedge aes_clk) begin
        if (aes_rst_n) begin
            read_cycles     <= '0;
            key_wait_cycles <= '0;
            cipher_cycles   <= '0;
            write_cycles    <= '0;
        end else begin
            case (state)
                S_RD_REQ, S_RD_WAIT, S_RD_ADV: read_cycles <= read_cycles + 1'b1;
                S_KEY, S_LAUNCH:               key_wait_cycles <= key_wait_cycles + 1'b1;
                S_CIPHER:                      cipher_cycles <= cipher_cycles + 1'b1;
                S_WR_SEL, S_WR_REQ, S_WR_WAIT, S_WR_ADV: write_cycles <= write_cycles + 1'b1;
                default: ;
            endcase
        end
    end

    a_req_exclusive: assert property (
        @(posedge aes_clk) disable iff (aes_rst_n)
        !(bram_start_read && bram_start_write)
    );

    // All cores launched together for exactly one cycle
    a_next_ready: assert property (
        @(posedge aes_clk) disable iff (aes_rst_n)
        (|core_next) |-> ((&core_ready) && (&core_next)) ##1 !(|core_next)
    );

endmodule

//--- aes_word_scatter.sv
`timescale 1ns/1ps

module aes_word_scatter #(
    parameter int N_LANES = 4
) (
    input  logic                                aes_clk,
    input  logic                                aes_rst_n,
    input  logic                                capture,
    input  aes_lane_pkg::block_t [N_LANES-1:0]  results,
    input  aes_bram_pkg::word_idx_t             word_idx,
    output aes_bram_pkg::word_t                 word
);

    localparam int WPB       = aes_lane_pkg::WORDS_PER_BLOCK;
    localparam int SUB_BITS  = $clog2(WPB);
    localparam int WORD_BITS = $bits(aes_bram_pkg::word_t);

    aes_lane_pkg::block_t [N_LANES-1:0] res_q;
    aes_lane_pkg::lane_idx_t            lane;
    logic [SUB_BITS-1:0]                sub;

    // All cores finish together, so take every lane at once
    always_ff @(posedge aes_clk) begin
        if (capture) begin
            res_q <= results;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Word select in BRAM order
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        lane = aes_lane_pkg::lane_idx_t'(word_idx / WPB);
        sub  = word_idx[SUB_BITS-1:0];
        word = res_q[lane][(WPB - 1 - sub) * WORD_BITS +: WORD_BITS];
    end

    // Write pass always starts from word 0 of the chunk
    a_capture_at_first_word: assert property (
        @(posedge aes_clk) disable iff (aes_rst_n)
        capture |-> (word_idx == '0)
    );

endmodule

//--- aes_word_gather.sv
`timescale 1ns/1ps

module aes_word_gather #(
    parameter int N_LANES = 4
) (
    input  logic                                aes_clk,
    input  logic                                aes_rst_n,
    input  logic                                store,
    input  aes_bram_pkg::word_idx_t             word_idx,
    input  aes_bram_pkg::word_t                 word,
    output aes_lane_pkg::block_t [N_LANES-1:0]  blocks
);

    localparam int WPB         = aes_lane_pkg::WORDS_PER_BLOCK;
    localparam int CHUNK_WORDS = N_LANES * WPB;
    localparam int WORD_BITS   = $bits(aes_bram_pkg::word_t);

    aes_bram_pkg::word_t word_mem [CHUNK_WORDS];

    // Read data lands in the same cycle as the BRAM answer
    always_ff @(posedge aes_clk) begin
        if (store) begin
            word_mem[word_idx] <= word;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Regroup words into lane blocks
    //////////////////////////////////////////////////////////////////////

    // Lane l takes words 4l..4l+3, first word in the top bits
    always_comb begin
        for (int l = 0; l < N_LANES; l++) begin
            for (int w = 0; w < WPB; w++) begin
                blocks[l][(WPB - 1 - w) * WORD_BITS +: WORD_BITS] = word_mem[l * WPB + w];
            end
        end
    end

    // Sequencer must wrap its index at the chunk size
    a_store_in_chunk: assert property (
        @(posedge aes_clk) disable iff (aes_rst_n)
        store |-> (int'(word_idx) < CHUNK_WORDS)
    );

endmodule

//--- aes_job_regs.sv
`timescale 1ns/1ps

module aes_job_regs (
    input  logic                 aes_clk,
    input  logic                 aes_rst_n,
    input  logic                 capture,
    input  aes_bram_pkg::count_t num_chunks,
    input  aes_bram_pkg::addr_t  read_base,
    input  aes_bram_pkg::addr_t  write_base,
    input  aes_lane_pkg::key_t   key,
    output aes_bram_pkg::count_t chunk_total,
    output aes_bram_pkg::addr_t  read_base_q,
    output aes_bram_pkg::addr_t  write_base_q,
    output logic                 reload_key
);

    aes_lane_pkg::key_t key_q;
    logic               key_changed;

    // Zero stored key means nothing loaded since reset
    assign key_changed = (key != key_q) || (key_q == '0);

    always_ff @(posedge aes_clk) begin
        if (aes_rst_n) begin
            key_q       <= '0;
            reload_key  <= 1'b0;
            chunk_total <= '0;
        end else if (capture) begin
            reload_key <= key_changed;
            key_q      <= key;
            if (num_chunks == '0) begin
                chunk_total <= aes_bram_pkg::count_t'(1);
            end else begin
                chunk_total <= num_chunks;
            end
        end
    end

    // Base addresses for the whole job
    always_ff @(posedge aes_clk) begin
        if (capture) begin
            read_base_q  <= read_base;
            write_base_q <= write_base;
        end
    end

endmodule

//--- aes_lane_pkg.sv
package aes_lane_pkg;

    //////////////////////////////////////////////////////////////////////
    // Cipher core payloads
    //////////////////////////////////////////////////////////////////////

    typedef logic [127:0] block_t;

    // 256-bit key mode only
    typedef logic [255:0] key_t;

    // BRAM words packed into one block, MSB word first
    localparam int WORDS_PER_BLOCK = 4;

    // Core number, up to four cores
    typedef logic [1:0] lane_idx_t;

endpackage

//--- aes_bram_pkg.sv
package aes_bram_pkg;

    //////////////////////////////////////////////////////////////////////
    // BRAM word and address
    //////////////////////////////////////////////////////////////////////

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;

    // Byte steps between words and between chunks
    localparam addr_t WORD_BYTES  = 32'd4;
    localparam addr_t CHUNK_BYTES = 32'd64;

    localparam int WORDS_PER_CHUNK = 16;

    // Word position within one chunk
    typedef logic [3:0] word_idx_t;

    // Chunk counts and status counters
    typedef logic [31:0] count_t;

endpackage
